/* Bender.yml */
package:
  name: front_end

sources:
  - include_dirs:
      - source
    files:
      - source/FetchPkg.sv
      - source/PriorityEncoder.sv
      - source/FetchBuffer.sv
      - source/InstrAligner.sv
      - source/FrontEnd.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/FrontEndTb.sv

/* bench/FrontEndTb.sv */
`include "fetch_consts.svh"

module FrontEndTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0] first;
        logic [1:0] last;
        logic [`FETCH_HWORDS-1:0][15:0] hw;
        logic [`FETCH_ID_BITS-1:0] id;
        FetchPkg::FaultKind fault;
        logic clr;
        logic stall;
    } PacketRow;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic is16;
        logic [`FETCH_ID_BITS-1:0] id;
        FetchPkg::FaultKind fault;
        logic [7:0] row;
    } ExpInstr;

    logic clk;
    logic rst;
    logic clear;
    logic fetchValid;
    logic [`PC_BITS-1:$clog2(`FETCH_HWORDS)+1] fetchPc;
    FetchPkg::FetchOff fetchFirst;
    FetchPkg::FetchOff fetchLast;
    logic [`FETCH_HWORDS-1:0][15:0] fetchData;
    logic [`FETCH_ID_BITS-1:0] fetchId;
    FetchPkg::FaultKind fetchFault;
    logic fetchFull;
    logic decReady;
    logic [`DEC_WIDTH-1:0] outValid;
    logic [`DEC_WIDTH-1:0][31:0] outInstr;
    logic [`DEC_WIDTH-1:0][`PC_BITS-1:0] outPc;
    logic [`DEC_WIDTH-1:0] out16;
    logic [`DEC_WIDTH-1:0][`FETCH_ID_BITS-1:0] outFetchId;
    FetchPkg::FaultKind [`DEC_WIDTH-1:0] outFault;

    PacketRow rows[$];
    string rowNames[$];
    ExpInstr expected[$];
    logic stallOn;
    logic sawFull;
    logic splitPending;
    logic [31:0] splitPc;
    logic [15:0] splitLow;
    int timeoutLimit;
    int cycleCount;

    FrontEnd i_FrontEnd (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchFirst(fetchFirst),
        .fetchLast(fetchLast),
        .fetchData(fetchData),
        .fetchId(fetchId),
        .fetchFault(fetchFault),
        .fetchFull(fetchFull),
        .decReady(decReady),
        .outValid(outValid),
        .outInstr(outInstr),
        .outPc(outPc),
        .out16(out16),
        .outFetchId(outFetchId),
        .outFault(outFault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Halfwords are written in offset order, offset 0 leftmost
    function automatic void addRow(string name, logic [31:0] pc, int first, int last,
                                   logic [63:0] hwords, int id, int fault, bit clr, bit stall);
        PacketRow p;
        p.pc = pc;
        p.first = 2'(first);
        p.last = 2'(last);
        for (int i = 0; i < `FETCH_HWORDS; i++) begin
            p.hw[i] = hwords[63 - 16 * i -: 16];
        end
        p.id = `FETCH_ID_BITS'(id);
        p.fault = FetchPkg::FaultKind'(fault);
        p.clr = clr;
        p.stall = stall;
        rows.push_back(p);
        rowNames.push_back(name);
    endfunction

    // ID and fault come from the row that holds the last halfword
    function automatic void addExpected(logic [31:0] pc, logic [31:0] instr, logic is16, int r);
        ExpInstr e;
        e.pc = pc;
        e.instr = instr;
        e.is16 = is16;
        e.id = rows[r].id;
        e.fault = rows[r].fault;
        e.row = 8'(r);
        expected.push_back(e);
    endfunction

    // Reference walk over the valid halfwords of one packet
    function automatic void modelPacket(int r);
        PacketRow p;
        int off;
        logic [15:0] h;
        p = rows[r];
        off = p.first;
        if (splitPending) begin
            addExpected(splitPc, {p.hw[0], splitLow}, 1'b0, r);
            splitPending = 1'b0;
            off = 1;
        end
        while (off <= p.last) begin
            h = p.hw[off];
            if (h[1:0] != 2'b11) begin
                addExpected(p.pc + 32'(2 * off), {16'h0, h}, 1'b1, r);
                off = off + 1;
            end else if (off == `FETCH_HWORDS - 1) begin
                splitPending = 1'b1;
                splitPc = p.pc + 32'(2 * off);
                splitLow = h;
                off = off + 1;
            end else begin
                addExpected(p.pc + 32'(2 * off), {p.hw[off + 1], h}, 1'b0, r);
                off = off + 2;
            end
        end
    endfunction

    // Decode stalls about 30% of the cycles in back-pressure rows
    task automatic nextCycle();
        @(negedge clk);
        if (stallOn) begin
            decReady = ($urandom_range(99) >= 30);
        end else begin
            decReady = 1'b1;
        end
    endtask

    task automatic checkSlot(int s);
        ExpInstr e;
        logic instrOk;
        string expStr;
        string actStr;
        assert (expected.size() != 0)
            else failRun($sformatf("Slot %0d delivered pc %h when no instruction was expected",
                                   s, outPc[s]));
        e = expected.pop_front();
        instrOk = e.is16 ? (outInstr[s][15:0] == e.instr[15:0]) : (outInstr[s] == e.instr);
        expStr = $sformatf("pc %h instr %h 16bit %b id %h fault %0d",
                           e.pc, e.instr, e.is16, e.id, e.fault);
        actStr = $sformatf("pc %h instr %h 16bit %b id %h fault %0d",
                           outPc[s], outInstr[s], out16[s], outFetchId[s], outFault[s]);
        assert (instrOk && outPc[s] == e.pc && out16[s] == e.is16 &&
                outFetchId[s] == e.id && outFault[s] == e.fault)
            else failRun($sformatf("** Error %s slot %0d expected %s actual %s",
                                   rowNames[e.row], s, expStr, actStr));
    endtask

    // Decode side consumes valid slots whenever it is ready
    always @(posedge clk) begin
        if (!rst) begin
            assert (outValid[0] || !outValid[1])
                else failRun("Slot 1 was valid while slot 0 was empty");
            if (decReady) begin
                for (int s = 0; s < `DEC_WIDTH; s++) begin
                    if (outValid[s]) begin
                        checkSlot(s);
                    end
                end
            end
            if (clear) begin
                expected.delete();
            end
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > timeoutLimit) begin
                failRun($sformatf("Timeout after %0d cycles, the pipeline stopped making progress",
                                  cycleCount));
            end
        end
    end

    initial begin
        rst = 1'b1;
        clear = 1'b0;
        fetchValid = 1'b0;
        fetchPc = '0;
        fetchFirst = '0;
        fetchLast = '0;
        fetchData = '0;
        fetchId = '0;
        fetchFault = FetchPkg::faultNone;
        decReady = 1'b1;
        stallOn = 1'b0;
        sawFull = 1'b0;
        splitPending = 1'b0;
        splitPc = '0;
        splitLow = '0;
        void'($urandom(32'h2cd4));

        // name, pc, first, last, halfwords, id, fault (0 none 1 page 2 access), clear, stall
        addRow("c16_a", 'h1000, 0, 3, 64'h4501_4582_8082_0405, 1, 0, 0, 0);
        addRow("c16_b", 'h1008, 0, 3, 64'h1141_c606_e022_0800, 2, 0, 0, 0);
        addRow("rv32_aligned", 'h1010, 0, 3, 64'h0513_0010_00b3_0020, 3, 0, 0, 0);
        addRow("mixed", 'h1018, 0, 3, 64'h4505_0293_0050_8082, 4, 0, 0, 0);
        addRow("split_lo", 'h1020, 0, 3, 64'h4501_0613_0000_0793, 5, 0, 0, 0);
        addRow("split_hi", 'h1028, 0, 3, 64'h1233_4601_0513_0001, 6, 0, 0, 0);
        addRow("split_lo_b", 'h1030, 0, 3, 64'h8082_4505_0001_0413, 7, 0, 0, 0);
        addRow("split_hi_fault", 'h1038, 0, 3, 64'h0044_8082_4501_0405, 8, 1, 0, 0);
        addRow("first_off", 'h1040, 2, 3, 64'h0513_ffff_4501_8082, 9, 0, 0, 0);
        addRow("last_off", 'h1048, 0, 1, 64'h4501_4502_0513_0000, 10, 0, 0, 0);
        addRow("mid_range", 'h1050, 1, 2, 64'h0000_0293_0060_0513, 11, 2, 0, 0);
        addRow("bp0", 'h1058, 0, 3, 64'h4501_4505_4509_450d, 12, 0, 0, 1);
        addRow("bp1", 'h1060, 0, 3, 64'h0513_0010_4582_8082, 13, 0, 0, 1);
        addRow("bp2", 'h1068, 0, 3, 64'h4601_4605_4609_0713, 14, 0, 0, 1);
        addRow("bp3", 'h1070, 0, 3, 64'h0020_4701_4705_4709, 15, 0, 0, 1);
        addRow("bp4", 'h1078, 0, 3, 64'h0593_0ff0_0613_0030, 0, 0, 0, 1);
        addRow("bp5", 'h1080, 0, 3, 64'h8082_8082_4781_47a1, 1, 0, 0, 1);
        addRow("bp6", 'h1088, 0, 3, 64'hc606_e022_1141_0800, 2, 0, 0, 1);
        addRow("bp7", 'h1090, 0, 3, 64'h4501_0513_0001_4505, 3, 0, 0, 1);
        addRow("pre_clear", 'h1098, 0, 3, 64'h4501_4505_4509_0793, 4, 0, 0, 1);
        addRow("clear_redirect", 'h2000, 0, 3, 64'h0513_0001_4501_8082, 5, 0, 1, 0);
        addRow("after_clear", 'h2008, 0, 3, 64'h4505_0293_0050_8082, 6, 1, 0, 0);
        timeoutLimit = 64 * rows.size() + 16;

        repeat (16) nextCycle();
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            stallOn = rows[i].stall;
            fetchValid = 1'b0;
            while (fetchFull) begin
                if (stallOn) begin
                    sawFull = 1'b1;
                end
                nextCycle();
            end
            if (rows[i].clr) begin
                // Redirect drops the pending split along with everything in flight
                clear = 1'b1;
                splitPending = 1'b0;
                nextCycle();
                clear = 1'b0;
            end
            fetchPc = rows[i].pc[`PC_BITS-1:$clog2(`FETCH_HWORDS)+1];
            fetchFirst = rows[i].first;
            fetchLast = rows[i].last;
            fetchData = rows[i].hw;
            fetchId = rows[i].id;
            fetchFault = rows[i].fault;
            fetchValid = 1'b1;
            modelPacket(i);
            nextCycle();
        end
        fetchValid = 1'b0;
        stallOn = 1'b0;

        for (int i = 0; i < 64 && expected.size() != 0; i++) begin
            nextCycle();
        end
        // A few idle cycles so a stray extra instruction is caught
        repeat (8) nextCycle();

        assert (sawFull)
            else failRun("fetchFull never rose while decode was stalling");

        assert (expected.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            failRun($sformatf("%0d expected instructions never reached decode, first from row %s",
                              expected.size(), rowNames[expected[0].row]));
        end
    end

endmodule

/* source/FetchBuffer.sv */
`include "fetch_consts.svh"

module FetchBuffer (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic push,
    input  FetchPkg::FetchPacket pushPacket,
    input  logic take,
    output FetchPkg::FetchPacket headPacket,
    output logic full
);

    localparam int ptrBits = $clog2(`FBUF_DEPTH);
    localparam logic [ptrBits-1:0] lastSlot = ptrBits'(`FBUF_DEPTH - 1);

    FetchPkg::FetchPacket mem [`FBUF_DEPTH];
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits:0] count;
    logic doPush;
    logic doPop;

    assign full = (count == (ptrBits + 1)'(`FBUF_DEPTH));
    assign doPush = push && !full;
    assign doPop = take && (count != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (clear) begin
            // Flush wins over a push in the same cycle
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            count <= count + (ptrBits + 1)'(doPush) - (ptrBits + 1)'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushPacket;
        end
    end

    // Head is visible straight from storage
    always_comb begin
        headPacket = mem[rdPtr];
        headPacket.valid = (count != '0);
    end

    // Fetch has to respect the full level
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("FetchBuffer: push while full");

    // The aligner only pops a packet it could see
    assert property (@(posedge clk) disable iff (rst) take |-> (count != '0))
        else $error("FetchBuffer: take while empty");

endmodule

/* source/FetchPkg.sv */
`include "fetch_consts.svh"

package FetchPkg;

    // Halfword position inside one fetch packet
    typedef logic [$clog2(`FETCH_HWORDS)-1:0] FetchOff;

    typedef enum logic [1:0] {
        faultNone = 2'd0,
        faultPage = 2'd1,
        faultAccess = 2'd2
    } FaultKind;

    typedef struct packed {
        logic valid;
        // Address bits above the halfword offset
        logic [`PC_BITS-1:$clog2(`FETCH_HWORDS)+1] pc;
        FetchOff firstValid;
        FetchOff lastValid;
        logic [`FETCH_HWORDS-1:0][15:0] hwords;
        logic [`FETCH_ID_BITS-1:0] fetchId;
        FaultKind fault;
    } FetchPacket;

    typedef struct packed {
        logic valid;
        logic [31:0] instr;
        // Halfword address of the first halfword
        logic [`PC_BITS-1:1] pc;
        logic is16bit;
        logic [`FETCH_ID_BITS-1:0] fetchId;
        FaultKind fault;
    } AlignedInstr;

endpackage

/* source/FrontEnd.sv */
`include "fetch_consts.svh"

module FrontEnd (
    input  logic clk,
    input  logic rst,
    input  logic clear,

    input  logic fetchValid,
    input  logic [`PC_BITS-1:$clog2(`FETCH_HWORDS)+1] fetchPc,
    input  FetchPkg::FetchOff fetchFirst,
    input  FetchPkg::FetchOff fetchLast,
    input  logic [`FETCH_HWORDS-1:0][15:0] fetchData,
    input  logic [`FETCH_ID_BITS-1:0] fetchId,
    input  FetchPkg::FaultKind fetchFault,
    output logic fetchFull,

    input  logic decReady,
    output logic [`DEC_WIDTH-1:0] outValid,
    output logic [`DEC_WIDTH-1:0][31:0] outInstr,
    output logic [`DEC_WIDTH-1:0][`PC_BITS-1:0] outPc,
    output logic [`DEC_WIDTH-1:0] out16,
    output logic [`DEC_WIDTH-1:0][`FETCH_ID_BITS-1:0] outFetchId,
    output FetchPkg::FaultKind [`DEC_WIDTH-1:0] outFault
);

    FetchPkg::FetchPacket pushPacket;
    FetchPkg::FetchPacket headPacket;
    FetchPkg::AlignedInstr alignedOut [`DEC_WIDTH];
    logic take;

    assign pushPacket = FetchPkg::FetchPacket'{
        valid: fetchValid,
        pc: fetchPc,
        firstValid: fetchFirst,
        lastValid: fetchLast,
        hwords: fetchData,
        fetchId: fetchId,
        fault: fetchFault
    };

    FetchBuffer i_FetchBuffer (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .push(fetchValid),
        .pushPacket(pushPacket),
        .take(take),
        .headPacket(headPacket),
        .full(fetchFull)
    );

    InstrAligner i_InstrAligner (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .inPacket(headPacket),
        .decReady(decReady),
        .take(take),
        .outInstr(alignedOut)
    );

    // Decode sees byte addresses
    for (genvar s = 0; s < `DEC_WIDTH; s++) begin : gDecPorts
        assign outValid[s] = alignedOut[s].valid;
        assign outInstr[s] = alignedOut[s].instr;
        assign outPc[s] = {alignedOut[s].pc, 1'b0};
        assign out16[s] = alignedOut[s].is16bit;
        assign outFetchId[s] = alignedOut[s].fetchId;
        assign outFault[s] = alignedOut[s].fault;
    end

endmodule

/* source/InstrAligner.sv */
`include "fetch_consts.svh"

module InstrAligner (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  FetchPkg::FetchPacket inPacket,
    input  logic decReady,
    output logic take,
    output FetchPkg::AlignedInstr outInstr [`DEC_WIDTH]
);

    localparam int hw = `FETCH_HWORDS;
    localparam int winSize = 2 * hw;
    localparam int idxBits = $clog2(winSize);
    localparam int offBits = $bits(FetchPkg::FetchOff);

    // Packet taken earlier, with its starts that decode has not received yet
    FetchPkg::FetchPacket heldPacket;
    logic [hw-1:0] heldStart;
    logic [hw-1:0] heldStart32;

    logic [hw-1:0] curStart;
    logic [hw-1:0] curStart32;
    logic heldSplit;
    logic heldSplitWait;
    logic curSplit;

    logic [winSize-1:0][15:0] window;
    logic [winSize-1:0] windowStart;
    logic [winSize-1:0] windowStart32;
    logic [winSize-1:0] unhandled;

    logic [`DEC_WIDTH-1:0][idxBits-1:0] pickIdx;
    logic [`DEC_WIDTH-1:0] pickValid;
    FetchPkg::AlignedInstr built [`DEC_WIDTH];

    logic [`DEC_WIDTH-1:0] slotValid;
    FetchPkg::AlignedInstr slotData [`DEC_WIDTH];
    logic outputReady;
    logic heldDone;

    // Held packet ends in the low half of a 32-bit instruction
    assign heldSplit = heldStart[hw-1] && heldStart32[hw-1];
    assign heldSplitWait = heldSplit && !inPacket.valid;
    assign curSplit = curStart32[hw-1];

    // Walk the incoming halfwords and mark where instructions begin
    always_comb begin
        logic canStart;
        logic is32;
        canStart = !heldSplit;
        for (int i = 0; i < hw; i++) begin
            is32 = (inPacket.hwords[i][1:0] == 2'b11);
            if (!inPacket.valid || FetchPkg::FetchOff'(i) < inPacket.firstValid ||
                FetchPkg::FetchOff'(i) > inPacket.lastValid) begin
                canStart = 1'b0;
            end
            if (canStart) begin
                curStart[i] = 1'b1;
                curStart32[i] = is32;
                canStart = !is32;
            end else begin
                curStart[i] = 1'b0;
                curStart32[i] = 1'b0;
                // After an upper half or an invalid slot the next one may start
                canStart = 1'b1;
            end
        end
    end

    assign window = {inPacket.hwords, heldPacket.hwords};

    always_comb begin
        windowStart = {curStart, heldStart};
        windowStart32 = {curStart32, heldStart32};
        // A 32-bit start is not usable until its upper half is in the window
        windowStart[winSize-1] = windowStart[winSize-1] & !curSplit;
        windowStart[hw-1] = windowStart[hw-1] & !heldSplitWait;
    end

    PriorityEncoder #(
        .width(winSize),
        .numOut(`DEC_WIDTH)
    ) i_PriorityEncoder (
        .data(windowStart),
        .idx(pickIdx),
        .idxValid(pickValid)
    );

    assign outputReady = !slotValid[0] || decReady;

    // Starts past the last picked slot stay pending
    always_comb begin
        for (int i = 0; i < winSize; i++) begin
            unhandled[i] = !outputReady ||
                (pickValid[`DEC_WIDTH-1] && (i > pickIdx[`DEC_WIDTH-1]));
        end
        unhandled[winSize-1] = unhandled[winSize-1] | curSplit;
        unhandled[hw-1] = unhandled[hw-1] | heldSplitWait;
    end

    assign heldDone = !(|(unhandled[hw-1:0] & windowStart[hw-1:0]));
    assign take = inPacket.valid && heldDone && outputReady;

    always_comb begin
        logic [idxBits-1:0] first;
        logic [idxBits-1:0] last;
        FetchPkg::FetchPacket firstPkt;
        FetchPkg::FetchPacket lastPkt;
        for (int s = 0; s < `DEC_WIDTH; s++) begin
            first = pickIdx[s];
            last = first + idxBits'(windowStart32[first]);
            firstPkt = first[idxBits-1] ? inPacket : heldPacket;
            // ID and fault follow the halfword that completes the instruction
            lastPkt = last[idxBits-1] ? inPacket : heldPacket;
            built[s].valid = pickValid[s];
            built[s].instr = {window[first + 1'b1], window[first]};
            built[s].pc = {firstPkt.pc, first[offBits-1:0]};
            built[s].is16bit = !windowStart32[first];
            built[s].fetchId = lastPkt.fetchId;
            built[s].fault = lastPkt.fault;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            heldStart <= '0;
            heldStart32 <= '0;
        end else if (clear) begin
            heldStart <= '0;
            heldStart32 <= '0;
        end else if (take) begin
            heldStart <= curStart & unhandled[winSize-1:hw];
            heldStart32 <= curStart32;
        end else begin
            heldStart <= heldStart & unhandled[hw-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            heldPacket <= inPacket;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slotValid <= '0;
        end else if (clear) begin
            slotValid <= '0;
        end else if (outputReady) begin
            slotValid <= pickValid;
        end
    end

    always_ff @(posedge clk) begin
        if (outputReady) begin
            slotData <= built;
        end
    end

    always_comb begin
        for (int s = 0; s < `DEC_WIDTH; s++) begin
            outInstr[s] = slotData[s];
            outInstr[s].valid = slotValid[s];
        end
    end

    for (genvar s = 0; s < `DEC_WIDTH; s++) begin : gSlotChecks
        if (s > 0) begin : gOrder
            // Slots are filled in program order
            assert property (@(posedge clk) disable iff (rst)
                slotValid[s] |-> slotValid[s-1])
                else $error("InstrAligner: slot %0d valid without slot %0d", s, s - 1);
        end
        // Held output while decode stalls
        assert property (@(posedge clk) disable iff (rst)
            slotValid[0] && !decReady && !clear |=>
                $stable(slotValid[s]) && $stable(slotData[s]))
            else $error("InstrAligner: slot %0d changed under back-pressure", s);
    end

endmodule

/* source/PriorityEncoder.sv */
module PriorityEncoder #(
    parameter int width = 8,
    parameter int numOut = 2,
    localparam int idxBits = $clog2(width)
) (
    input  logic [width-1:0] data,
    output logic [numOut-1:0][idxBits-1:0] idx,
    output logic [numOut-1:0] idxValid
);

    always_comb begin
        logic [width-1:0] remaining;
        remaining = data;
        for (int o = 0; o < numOut; o++) begin
            idx[o] = '0;
            idxValid[o] = |remaining;
            // Scan downward so the lowest set bit is the one kept
            for (int i = width - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    idx[o] = idxBits'(i);
                end
            end
            // Knock out the bit just found before the next search
            remaining = remaining & (remaining - 1'b1);
        end
    end

endmodule

/* source/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Halfwords delivered by fetch in one packet
`define FETCH_HWORDS 4

// Instruction slots handed to decode per cycle
`define DEC_WIDTH 2

// Packets the fetch buffer can hold
`define FBUF_DEPTH 4

// Byte address width
`define PC_BITS 32

`define FETCH_ID_BITS 4

`endif

/* sources.f */
+incdir+source
source/FetchPkg.sv
source/PriorityEncoder.sv
source/FetchBuffer.sv
source/InstrAligner.sv
source/FrontEnd.sv
bench/FrontEndTb.sv
